// ==== Bender.yml ====
package:
  name: frontend

sources:
  - files:
      - hw/frontend_pkg.sv
      - hw/fetch_block_if.sv
      - hw/pc_gen.sv
      - hw/ftq.sv
      - hw/ifu.sv
      - hw/frontend.sv
  - target: test
    files:
      - verification/tb_frontend.sv

// ==== hw/fetch_block_if.sv ====
`timescale 1ns/1ps

interface fetch_block_if;
    import frontend_pkg::*;

    logic     valid;
    logic     ready;
    addr_t    start_pc;
    blk_len_t length;
    logic     pred_taken;
    addr_t    pred_target;

    modport producer (
        output valid,
        output start_pc,
        output length,
        output pred_taken,
        output pred_target,
        input  ready
    );

    modport consumer (
        input  valid,
        input  start_pc,
        input  length,
        input  pred_taken,
        input  pred_target,
        output ready
    );

endinterface

// ==== hw/frontend.sv ====
`timescale 1ns/1ps

module frontend #(
    parameter int FETCH_WIDTH = frontend_pkg::FETCH_WIDTH,
    parameter int FTQ_DEPTH   = 8,
    parameter int BTB_ENTRIES = 16
) (
    input  logic                                    clk,
    input  logic                                    rst_n,

    input  logic                                    backend_flush_i,
    input  frontend_pkg::addr_t                     backend_next_pc_i,
    input  logic                                    backend_update_valid_i,
    input  frontend_pkg::addr_t                     backend_update_pc_i,
    input  frontend_pkg::addr_t                     backend_update_target_i,

    output logic                                    icache_req_o,
    output frontend_pkg::addr_t                     icache_addr_o,
    input  logic                                    icache_ack_i,
    input  frontend_pkg::instr_t [FETCH_WIDTH-1:0]  icache_rdata_i,

    input  logic                                    instr_buffer_stall_i,
    output logic [FETCH_WIDTH-1:0]                  instr_valid_o,
    output frontend_pkg::addr_t  [FETCH_WIDTH-1:0]  instr_pc_o,
    output frontend_pkg::instr_t [FETCH_WIDTH-1:0]  instr_word_o
);

    fetch_block_if bp2ftq ();
    fetch_block_if ftq2ifu ();

    pc_gen #(
        .BTB_ENTRIES(BTB_ENTRIES)
    ) u_pc_gen (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush_i        (backend_flush_i),
        .flush_pc_i     (backend_next_pc_i),
        .update_valid_i (backend_update_valid_i),
        .update_pc_i    (backend_update_pc_i),
        .update_target_i(backend_update_target_i),
        .blk_o          (bp2ftq)
    );

    ftq #(
        .FTQ_DEPTH(FTQ_DEPTH)
    ) u_ftq (
        .clk    (clk),
        .rst_n  (rst_n),
        .flush_i(backend_flush_i),
        .enq    (bp2ftq),
        .deq    (ftq2ifu)
    );

    ifu #(
        .FETCH_WIDTH(FETCH_WIDTH)
    ) u_ifu (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (backend_flush_i),
        .blk_i         (ftq2ifu),
        .icache_req_o  (icache_req_o),
        .icache_addr_o (icache_addr_o),
        .icache_ack_i  (icache_ack_i),
        .icache_rdata_i(icache_rdata_i),
        .stall_i       (instr_buffer_stall_i),
        .instr_valid_o (instr_valid_o),
        .instr_pc_o    (instr_pc_o),
        .instr_word_o  (instr_word_o)
    );

endmodule

// ==== hw/frontend_pkg.sv ====
package frontend_pkg;

    // One instruction address, one 32-bit word
    typedef logic [31:0] addr_t;

    typedef logic [31:0] instr_t;

    // Fetch geometry, one cache line per fetch
    parameter int FETCH_WIDTH = 4;
    parameter int LINE_BYTES  = FETCH_WIDTH * 4;

    // Block length in instructions, 1 to FETCH_WIDTH
    typedef logic [2:0] blk_len_t;

    parameter addr_t RESET_PC = 32'h1c00_0000;

    // Fetch unit cache handshake states
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        DRAIN,
        OUT
    } ifu_state_e;

endpackage

// ==== hw/ftq.sv ====
`timescale 1ns/1ps

module ftq #(
    parameter int FTQ_DEPTH = 8
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            flush_i,
    fetch_block_if.consumer enq,
    fetch_block_if.producer deq
);
    import frontend_pkg::*;

    localparam int PTR_W = $clog2(FTQ_DEPTH);

    typedef struct packed {
        addr_t    start_pc;
        blk_len_t length;
        logic     pred_taken;
        addr_t    pred_target;
    } entry_t;

    entry_t mem [FTQ_DEPTH];

    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [PTR_W:0]   count_q;
    logic             push;
    logic             pop;
    entry_t           head_entry;

    // Wrap for depths that are not a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FTQ_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign enq.ready = (count_q != (PTR_W + 1)'(FTQ_DEPTH));
    assign deq.valid = (count_q != '0);

    assign push = enq.valid && enq.ready;
    assign pop  = deq.valid && deq.ready;

    assign head_entry      = mem[head_q];
    assign deq.start_pc    = head_entry.start_pc;
    assign deq.length      = head_entry.length;
    assign deq.pred_taken  = head_entry.pred_taken;
    assign deq.pred_target = head_entry.pred_target;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (push) begin
                tail_q <= next_ptr(tail_q);
            end
            if (pop) begin
                head_q <= next_ptr(head_q);
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[tail_q] <= '{
                start_pc:    enq.start_pc,
                length:      enq.length,
                pred_taken:  enq.pred_taken,
                pred_target: enq.pred_target
            };
        end
    end

endmodule

// ==== hw/ifu.sv ====
`timescale 1ns/1ps

module ifu #(
    parameter int FETCH_WIDTH = frontend_pkg::FETCH_WIDTH
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    flush_i,
    fetch_block_if.consumer                         blk_i,
    output logic                                    icache_req_o,
    output frontend_pkg::addr_t                     icache_addr_o,
    input  logic                                    icache_ack_i,
    input  frontend_pkg::instr_t [FETCH_WIDTH-1:0]  icache_rdata_i,
    input  logic                                    stall_i,
    output logic [FETCH_WIDTH-1:0]                  instr_valid_o,
    output frontend_pkg::addr_t  [FETCH_WIDTH-1:0]  instr_pc_o,
    output frontend_pkg::instr_t [FETCH_WIDTH-1:0]  instr_word_o
);
    import frontend_pkg::*;

    localparam int OFF_W  = $clog2(FETCH_WIDTH * 4);
    localparam int SLOT_W = $clog2(FETCH_WIDTH);

    ifu_state_e state_q;
    ifu_state_e state_d;
    logic       req_q;
    logic       req_d;
    logic       blk_fire;
    logic       ack_first;

    addr_t                     start_pc_q;
    blk_len_t                  len_q;
    instr_t [FETCH_WIDTH-1:0]  data_q;

    addr_t                  line_addr;
    logic [SLOT_W-1:0]      start_slot;
    logic [FETCH_WIDTH-1:0] slot_mask;

    // Never take a block in the flush cycle, it is stale
    assign blk_i.ready = (state_q == IDLE) && !flush_i;
    assign blk_fire    = blk_i.valid && blk_i.ready;

    assign ack_first = req_q && icache_ack_i;

    always_comb begin
        state_d = state_q;
        req_d   = req_q;
        case (state_q)
            IDLE: begin
                if (blk_fire) begin
                    state_d = REQ;
                    req_d   = 1'b1;
                end
            end
            REQ, DRAIN: begin
                if (ack_first) begin
                    req_d = 1'b0;
                end
                // Four phases done once req and ack are both low
                if (!req_q && !icache_ack_i) begin
                    state_d = (state_q == REQ && !flush_i) ? OUT : IDLE;
                end else if (flush_i) begin
                    state_d = DRAIN;
                end
            end
            OUT: begin
                if (flush_i || !stall_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            req_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            req_q   <= req_d;
        end
    end

    always_ff @(posedge clk) begin
        if (blk_fire) begin
            start_pc_q <= blk_i.start_pc;
            len_q      <= blk_i.length;
        end
        if (state_q == REQ && ack_first) begin
            data_q <= icache_rdata_i;
        end
    end

    assign start_slot = start_pc_q[OFF_W-1:2];
    assign line_addr  = {start_pc_q[31:OFF_W], {OFF_W{1'b0}}};

    assign icache_req_o  = req_q;
    assign icache_addr_o = line_addr;

    for (genvar i = 0; i < FETCH_WIDTH; i++) begin : g_slot
        assign slot_mask[i]    = (i >= int'(start_slot))
                                 && (i < int'(start_slot) + int'(len_q));
        assign instr_pc_o[i]   = line_addr + addr_t'(4 * i);
        assign instr_word_o[i] = data_q[i];
    end

    // Flush kills the presented block in the same cycle
    assign instr_valid_o = (state_q == OUT && !flush_i) ? slot_mask : '0;

endmodule

// ==== hw/pc_gen.sv ====
`timescale 1ns/1ps

module pc_gen #(
    parameter int BTB_ENTRIES = 16
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush_i,
    input  frontend_pkg::addr_t flush_pc_i,
    input  logic                update_valid_i,
    input  frontend_pkg::addr_t update_pc_i,
    input  frontend_pkg::addr_t update_target_i,
    fetch_block_if.producer     blk_o
);
    import frontend_pkg::*;

    localparam int IDX_W  = $clog2(BTB_ENTRIES);
    localparam int TAG_W  = 30 - IDX_W;
    localparam int OFF_W  = $clog2(LINE_BYTES);
    localparam int SLOT_W = $clog2(FETCH_WIDTH);

    addr_t pc_q;
    addr_t next_pc;
    addr_t line_addr;
    logic [SLOT_W-1:0] start_slot;

    // Direct-mapped BTB
    logic [BTB_ENTRIES-1:0] btb_valid;
    logic [TAG_W-1:0]       btb_tag    [BTB_ENTRIES];
    addr_t                  btb_target [BTB_ENTRIES];

    logic [FETCH_WIDTH-1:0] slot_hit;
    addr_t                  slot_target [FETCH_WIDTH];

    logic              hit_found;
    logic [SLOT_W-1:0] hit_slot;
    addr_t             hit_target;
    blk_len_t          blk_len;

    assign start_slot = pc_q[OFF_W-1:2];
    assign line_addr  = {pc_q[31:OFF_W], {OFF_W{1'b0}}};

    // Look up every slot of the line, earlier slots masked off
    for (genvar i = 0; i < FETCH_WIDTH; i++) begin : g_lookup
        addr_t            slot_pc;
        logic [IDX_W-1:0] idx;

        assign slot_pc        = line_addr + addr_t'(4 * i);
        assign idx            = slot_pc[IDX_W+1:2];
        assign slot_hit[i]    = (SLOT_W'(i) >= start_slot) && btb_valid[idx]
                                && (btb_tag[idx] == slot_pc[31:IDX_W+2]);
        assign slot_target[i] = btb_target[idx];
    end

    // First hit wins
    always_comb begin
        hit_found  = 1'b0;
        hit_slot   = '0;
        hit_target = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (!hit_found && slot_hit[i]) begin
                hit_found  = 1'b1;
                hit_slot   = SLOT_W'(i);
                hit_target = slot_target[i];
            end
        end
    end

    always_comb begin
        if (hit_found) begin
            blk_len = blk_len_t'(hit_slot) - blk_len_t'(start_slot) + blk_len_t'(1);
            next_pc = hit_target;
        end else begin
            blk_len = blk_len_t'(FETCH_WIDTH) - blk_len_t'(start_slot);
            next_pc = line_addr + addr_t'(LINE_BYTES);
        end
    end

    // No block offered while the backend redirects
    assign blk_o.valid       = !flush_i;
    assign blk_o.start_pc    = pc_q;
    assign blk_o.length      = blk_len;
    assign blk_o.pred_taken  = hit_found;
    assign blk_o.pred_target = hit_target;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else if (flush_i) begin
            pc_q <= flush_pc_i;
        end else if (blk_o.valid && blk_o.ready) begin
            pc_q <= next_pc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            btb_valid <= '0;
        end else if (update_valid_i) begin
            btb_valid[update_pc_i[IDX_W+1:2]] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (update_valid_i) begin
            btb_tag[update_pc_i[IDX_W+1:2]]    <= update_pc_i[31:IDX_W+2];
            btb_target[update_pc_i[IDX_W+1:2]] <= update_target_i;
        end
    end

endmodule

// ==== sim.f ====
hw/frontend_pkg.sv
hw/fetch_block_if.sv
hw/pc_gen.sv
hw/ftq.sv
hw/ifu.sv
hw/frontend.sv
verification/tb_frontend.sv

// ==== verification/tb_frontend.sv ====
`timescale 1ns/1ps

module tb_frontend;
    import frontend_pkg::*;

    localparam int FW          = FETCH_WIDTH;
    localparam int FTQ_DEPTH   = 8;
    localparam int BTB_ENTRIES = 16;
    localparam int SEED        = 32'hc646_d5ee;
    localparam int RST_CYCLES  = 5;
    localparam int T1_CYCLES   = 400;
    localparam int T2_CYCLES   = 400;
    localparam int T3_CYCLES   = 300;
    localparam int T4_CYCLES   = 1500;
    localparam int T5_CYCLES   = 400;
    localparam int WATCHDOG_NS = (RST_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES
                                  + T4_CYCLES + T5_CYCLES) * 4 * 2;
    localparam int OFF_W       = $clog2(LINE_BYTES);

    logic                clk;
    logic                rst_n;
    logic                backend_flush_i;
    addr_t               backend_next_pc_i;
    logic                backend_update_valid_i;
    addr_t               backend_update_pc_i;
    addr_t               backend_update_target_i;
    logic                icache_req_o;
    addr_t               icache_addr_o;
    logic                icache_ack_i;
    instr_t [FW-1:0]     icache_rdata_i;
    logic                instr_buffer_stall_i;
    logic [FW-1:0]       instr_valid_o;
    addr_t  [FW-1:0]     instr_pc_o;
    instr_t [FW-1:0]     instr_word_o;

    // Reference model of the PC generator and its BTB
    addr_t model_pc;
    logic  model_btb_valid [BTB_ENTRIES];
    addr_t model_btb_pc    [BTB_ENTRIES];
    addr_t model_btb_tgt   [BTB_ENTRIES];

    int              errors;
    int              proto_errors;
    int              blk_count;
    int              tests_passed;
    int              tests_failed;
    logic [FW-1:0]   last_mask;
    addr_t           last_start;
    logic            prev_req;
    logic            prev_ack;
    addr_t           prev_addr;
    logic            held;
    logic [FW-1:0]   held_mask;
    addr_t  [FW-1:0] held_pc;
    instr_t [FW-1:0] held_word;

    frontend #(
        .FETCH_WIDTH(FW),
        .FTQ_DEPTH  (FTQ_DEPTH),
        .BTB_ENTRIES(BTB_ENTRIES)
    ) dut0 (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .backend_flush_i        (backend_flush_i),
        .backend_next_pc_i      (backend_next_pc_i),
        .backend_update_valid_i (backend_update_valid_i),
        .backend_update_pc_i    (backend_update_pc_i),
        .backend_update_target_i(backend_update_target_i),
        .icache_req_o           (icache_req_o),
        .icache_addr_o          (icache_addr_o),
        .icache_ack_i           (icache_ack_i),
        .icache_rdata_i         (icache_rdata_i),
        .instr_buffer_stall_i   (instr_buffer_stall_i),
        .instr_valid_o          (instr_valid_o),
        .instr_pc_o             (instr_pc_o),
        .instr_word_o           (instr_word_o)
    );

    always #2 clk = ~clk;

    task automatic step();
        @(posedge clk);
        #0.5;
    endtask

    task automatic flag_error(input string msg);
        $display("Error at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic check_pc(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input instr_t got, input instr_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    task automatic check_mask(input string name, input logic [FW-1:0] got,
                              input logic [FW-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    // First BTB hit after the model PC cuts the expected block
    task automatic expect_block();
        addr_t         line;
        addr_t         slot_pc;
        addr_t         next_pc;
        int            start;
        int            len;
        int            idx;
        logic          hit;
        logic [FW-1:0] mask;

        line    = model_pc & ~addr_t'(LINE_BYTES - 1);
        start   = int'((model_pc - line) >> 2);
        len     = FW - start;
        next_pc = line + addr_t'(LINE_BYTES);
        hit     = 1'b0;
        for (int i = start; i < FW; i++) begin
            slot_pc = line + addr_t'(4 * i);
            idx     = int'((slot_pc >> 2) % BTB_ENTRIES);
            if (!hit && model_btb_valid[idx] && model_btb_pc[idx] == slot_pc) begin
                hit     = 1'b1;
                len     = i - start + 1;
                next_pc = model_btb_tgt[idx];
            end
        end
        mask = '0;
        for (int i = start; i < start + len; i++) begin
            mask[i] = 1'b1;
        end
        check_mask("instr_valid_o", instr_valid_o, mask);
        for (int i = start; i < start + len; i++) begin
            slot_pc = line + addr_t'(4 * i);
            check_pc($sformatf("instr_pc_o[%0d]", i), instr_pc_o[i], slot_pc);
            check_word($sformatf("instr_word_o[%0d]", i), instr_word_o[i],
                       slot_pc ^ 32'hdead_beef);
        end
        last_mask  = instr_valid_o;
        last_start = instr_pc_o[start];
        model_pc   = next_pc;
        blk_count++;
    endtask

    // Per-cycle monitor sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (icache_req_o && !prev_req && prev_ack) begin
                flag_error("icache_req_o rose while icache_ack_i was still high");
                proto_errors++;
            end
            if (icache_req_o && icache_addr_o[OFF_W-1:0] != '0) begin
                flag_error("icache_addr_o is not line aligned while req is high");
                proto_errors++;
            end
            if (icache_req_o && prev_req) begin
                check_pc("icache_addr_o", icache_addr_o, prev_addr);
            end
            if (held && !backend_flush_i) begin
                check_mask("instr_valid_o under stall", instr_valid_o, held_mask);
                for (int i = 0; i < FW; i++) begin
                    if (held_mask[i]) begin
                        check_pc($sformatf("instr_pc_o[%0d] under stall", i),
                                 instr_pc_o[i], held_pc[i]);
                        check_word($sformatf("instr_word_o[%0d] under stall", i),
                                   instr_word_o[i], held_word[i]);
                    end
                end
            end
            held      = (instr_valid_o != '0) && instr_buffer_stall_i;
            held_mask = instr_valid_o;
            held_pc   = instr_pc_o;
            held_word = instr_word_o;
            if (instr_valid_o != '0 && !instr_buffer_stall_i) begin
                expect_block();
            end
        end
        prev_req  = icache_req_o;
        prev_ack  = icache_ack_i;
        prev_addr = icache_addr_o;
    end

    // Four-phase cache responder
    initial begin : cache_model
        int delay;
        forever begin
            step();
            if (rst_n && icache_req_o && !icache_ack_i) begin
                delay = $urandom_range(0, 3);
                repeat (delay) step();
                for (int i = 0; i < FW; i++) begin
                    icache_rdata_i[i] = (icache_addr_o + addr_t'(4 * i)) ^ 32'hdead_beef;
                end
                icache_ack_i = 1'b1;
                do begin
                    step();
                end while (icache_req_o);
                icache_ack_i = 1'b0;
            end
        end
    end

    task automatic apply_reset();
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            model_btb_valid[i] = 1'b0;
        end
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #0.5;
        if (icache_req_o !== 1'b0) begin
            flag_error("icache_req_o is not low after reset");
        end
        check_mask("instr_valid_o after reset", instr_valid_o, '0);
        model_pc = RESET_PC;
        rst_n    = 1'b1;
    endtask

    task automatic flush_to(input addr_t pc);
        backend_flush_i   = 1'b1;
        backend_next_pc_i = pc;
        model_pc          = pc;
        step();
        backend_flush_i   = 1'b0;
    endtask

    task automatic train_btb(input addr_t pc, input addr_t target);
        int idx;
        idx = int'((pc >> 2) % BTB_ENTRIES);
        backend_update_valid_i  = 1'b1;
        backend_update_pc_i     = pc;
        backend_update_target_i = target;
        model_btb_valid[idx]    = 1'b1;
        model_btb_pc[idx]       = pc;
        model_btb_tgt[idx]      = target;
        step();
        backend_update_valid_i  = 1'b0;
    endtask

    task automatic wait_blocks(input int n, input int budget);
        int target;
        int cycles;
        target = blk_count + n;
        cycles = 0;
        while (blk_count < target && cycles < budget) begin
            step();
            cycles++;
        end
        if (blk_count < target) begin
            flag_error($sformatf("timed out waiting for %0d blocks, fetch unit in state %s",
                                 n, dut0.u_ifu.state_q.name()));
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        if (errors == err_before) begin
            tests_passed++;
            $display("Test %s: ok, %0d blocks checked so far", name, blk_count);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, errors - err_before);
        end
    endtask

    task automatic test_sequential();
        int err0;
        err0 = errors;
        wait_blocks(12, T1_CYCLES);
        finish_test("sequential fetch", err0);
    endtask

    task automatic test_flush();
        int err0;
        int n;
        err0 = errors;
        flush_to(32'h1c00_1008);
        wait_blocks(3, T2_CYCLES / 2);
        // Second flush lands while a cache request is open
        n = 0;
        while (!icache_req_o && n < T2_CYCLES / 4) begin
            step();
            n++;
        end
        if (!icache_req_o) begin
            flag_error("icache_req_o never rose before the second flush");
        end
        flush_to(32'h1c00_2004);
        wait_blocks(3, T2_CYCLES / 4);
        finish_test("unaligned start and flush", err0);
    endtask

    task automatic test_branch();
        int err0;
        err0 = errors;
        train_btb(32'h1c00_3008, 32'h1c00_4004);
        flush_to(32'h1c00_3000);
        wait_blocks(1, T3_CYCLES / 3);
        check_mask("instr_valid_o of branch block", last_mask, {{(FW - 3){1'b0}}, 3'b111});
        wait_blocks(1, T3_CYCLES / 3);
        check_pc("first slot after branch", last_start, 32'h1c00_4004);
        wait_blocks(2, T3_CYCLES / 3);
        finish_test("predicted branch", err0);
    endtask

    task automatic test_backpressure();
        int err0;
        int target;
        int n;
        int span;
        err0 = errors;
        flush_to(32'h1c00_5000);
        target = blk_count + 20;
        // Stall until the queue is full
        instr_buffer_stall_i = 1'b1;
        n = 0;
        while (dut0.u_ftq.count_q != FTQ_DEPTH && n < 4 * FTQ_DEPTH) begin
            step();
            n++;
        end
        if (dut0.u_ftq.count_q != FTQ_DEPTH) begin
            flag_error("fetch target queue did not fill while the output was stalled");
        end
        while (blk_count < target && n < T4_CYCLES) begin
            instr_buffer_stall_i = $urandom_range(0, 1);
            span = $urandom_range(1, 6);
            repeat (span) begin
                step();
                n++;
            end
        end
        instr_buffer_stall_i = 1'b0;
        if (blk_count < target) begin
            flag_error("blocks stopped arriving under back-pressure");
        end
        finish_test("back-pressure", err0);
    endtask

    task automatic test_handshake();
        int err0;
        err0 = errors;
        flush_to(32'h1c00_6000);
        wait_blocks(2, T5_CYCLES / 3);
        for (int k = 1; k <= 3; k++) begin
            repeat ($urandom_range(1, 5)) step();
            flush_to(32'h1c00_6000 + addr_t'(k * 36));
        end
        wait_blocks(4, T5_CYCLES / 2);
        if (proto_errors != 0) begin
            flag_error($sformatf("%0d cache handshake violations during the run",
                                 proto_errors));
        end
        finish_test("handshake discipline", err0);
    endtask

    initial begin
        clk                     = 1'b0;
        rst_n                   = 1'b0;
        backend_flush_i         = 1'b0;
        backend_next_pc_i       = '0;
        backend_update_valid_i  = 1'b0;
        backend_update_pc_i     = '0;
        backend_update_target_i = '0;
        icache_ack_i            = 1'b0;
        icache_rdata_i          = '0;
        instr_buffer_stall_i    = 1'b0;
        errors                  = 0;
        proto_errors            = 0;
        blk_count               = 0;
        tests_passed            = 0;
        tests_failed            = 0;
        held                    = 1'b0;
        void'($urandom(SEED));
        apply_reset();
        test_sequential();
        test_flush();
        test_branch();
        test_backpressure();
        test_handshake();
        $display("Tests passed: %0d, failed: %0d, check errors: %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: run exceeded %0d ns, fetch unit in state %s",
                 WATCHDOG_NS, dut0.u_ifu.state_q.name());
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule
